/* cache_controller.sv */
`include "cache_params.svh"

module cache_controller (
    input  logic                  clk,
    input  logic                  rstn,
    input  cache_pkg::wb_req_t    wb_req,
    output cache_pkg::wb_rsp_t    wb_rsp,
    output logic [3:0]            index,
    output logic [5:0]            req_tag,
    input  cache_pkg::tag_entry_t entry,
    input  logic                  hit,
    input  logic                  ready,
    output logic                  tag_we,
    output cache_pkg::tag_entry_t wentry,
    input  cache_pkg::line_t      line,
    output logic [1:0]            word,
    output logic                  word_we,
    output logic [31:0]           wdata,
    output logic                  fill_we,
    output cache_pkg::line_t      fill_line,
    output cache_pkg::mem_cmd_t   mem_cmd,
    input  cache_pkg::mem_rsp_t   mem_rsp
);

    typedef enum logic [2:0] {
        S_IDLE, S_LOOKUP, S_COMPARE, S_WRBACK, S_FETCH, S_FILL, S_ACK
    } state_t;

    state_t state;
    state_t state_nx;

    logic             issue;
    logic             issue_write;
    logic [7:0]       issue_addr;
    logic             start_q;
    logic             pending;
    logic             cmd_write;
    logic [7:0]       cmd_addr;
    cache_pkg::line_t cmd_line;
    cache_pkg::line_t fill_q;

    // both stores are indexed straight from the held request address.
    assign index   = wb_req.adr.fields.index;
    assign req_tag = wb_req.adr.fields.tag;
    assign word    = wb_req.adr.fields.word;
    assign wdata   = wb_req.dat;

    assign wb_rsp  = '{ack: state == S_ACK, dat: line[word]};

    assign word_we   = (state == S_ACK) && wb_req.we;
    assign fill_we   = (state == S_FILL);
    assign fill_line = fill_q;
    assign tag_we    = word_we || fill_we;
    assign wentry    = '{tag: req_tag, dirty: state == S_ACK, valid: 1'b1}; // fill is clean.

    always_comb begin
        state_nx = state;
        case (state)
            S_IDLE:    if (ready && wb_req.cyc && wb_req.stb) state_nx = S_LOOKUP;
            S_LOOKUP:  state_nx = S_COMPARE;
            S_COMPARE: begin
                if (hit) begin
                    state_nx = S_ACK;
                end else if (entry.valid && entry.dirty) begin
                    state_nx = S_WRBACK;
                end else begin
                    state_nx = S_FETCH;
                end
            end
            S_WRBACK:  if (mem_rsp.done) state_nx = S_FETCH;
            S_FETCH:   if (mem_rsp.done) state_nx = S_FILL;
            S_FILL:    state_nx = S_LOOKUP; // read again so the retry sees the new line.
            S_ACK:     state_nx = S_IDLE;
            default:   state_nx = S_IDLE;
        endcase
    end

    // a miss starts either the write-back or the fetch, and the end of a
    // write-back starts the fetch.
    always_comb begin
        issue       = 1'b0;
        issue_write = 1'b0;
        issue_addr  = {req_tag[3:0], index};
        if (state == S_COMPARE && !hit) begin
            issue       = 1'b1;
            issue_write = entry.valid && entry.dirty;
            if (issue_write) begin
                issue_addr = {entry.tag[3:0], index}; // victim line.
            end
        end else if (state == S_WRBACK && mem_rsp.done) begin
            issue = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= S_IDLE;
            start_q <= 1'b0;
            pending <= 1'b0;
        end else begin
            state   <= state_nx;
            start_q <= issue;
            if (start_q) begin
                pending <= 1'b1;
            end else if (mem_rsp.done) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            cmd_write <= issue_write;
            cmd_addr  <= issue_addr;
            cmd_line  <= line;
        end
        if (state == S_FETCH && mem_rsp.done) begin
            fill_q <= mem_rsp.line;
        end
    end

    assign mem_cmd = '{start: start_q, write: cmd_write, addr: cmd_addr, line: cmd_line};

    a_ack_in_cycle : assert property (
        @(posedge clk) disable iff (!rstn)
        wb_rsp.ack |-> wb_req.cyc && wb_req.stb
    );

    a_one_transfer : assert property (
        @(posedge clk) disable iff (!rstn)
        start_q |-> !pending
    );

    a_addr_in_range : assert property (
        @(posedge clk) disable iff (!rstn)
        wb_req.cyc && wb_req.stb |-> wb_req.adr.raw < 32'(`MEM_LINES * `LINE_WORDS * 4)
    );

endmodule

/* cache_data_store.sv */
`include "cache_params.svh"

module cache_data_store (
    input  logic             clk,
    input  logic [3:0]       index,
    input  logic [1:0]       word,
    input  logic             word_we,
    input  logic [31:0]      wdata,
    input  logic             fill_we,
    input  cache_pkg::line_t fill_line,
    output cache_pkg::line_t line
);

    // one bank per word position in the line.
    logic [31:0] bank [`LINE_WORDS][`CACHE_LINES];

    logic [`LINE_WORDS-1:0] word_sel;

    // one-hot select of the bank that a core write reaches.
    always_comb begin
        word_sel = '0;
        for (int b = 0; b < `LINE_WORDS; b++) begin
            if (word == 2'(b)) begin
                word_sel[b] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < `LINE_WORDS; b++) begin
            if (fill_we) begin
                bank[b][index] <= fill_line[b];
            end else if (word_we && word_sel[b]) begin
                bank[b][index] <= wdata;
            end
            line[b] <= bank[b][index];
        end
    end

    // a fill and a core write to the same line never overlap.
    a_single_writer : assert property (
        @(posedge clk)
        word_we |-> !fill_we
    );

endmodule

/* cache_miss_handler.sv */
module cache_miss_handler (
    input  logic                clk,
    input  logic                rstn,
    input  cache_pkg::mem_cmd_t cmd,
    output cache_pkg::mem_rsp_t rsp,
    output cache_pkg::mem_cmd_t mem_cmd,
    input  cache_pkg::mem_rsp_t mem_rsp
);

    logic             busy;
    logic             start_q;
    logic             lat_write;
    logic [7:0]       lat_addr;
    cache_pkg::line_t lat_line;

    // the start to the memory follows the controller's start by one cycle.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy    <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= cmd.start;
            if (cmd.start) begin
                busy <= 1'b1;
            end else if (mem_rsp.done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.start) begin
            lat_write <= cmd.write;
            lat_addr  <= cmd.addr;
            lat_line  <= cmd.line;
        end
    end

    assign mem_cmd = '{start: start_q, write: lat_write, addr: lat_addr, line: lat_line};

    // done passes straight through, so the controller sees it one cycle
    // later than the memory latency alone.
    always_comb begin
        rsp.done = busy && mem_rsp.done;
        rsp.line = lat_write ? lat_line : mem_rsp.line; // a write echoes what it stored.
    end

    a_no_cmd_while_busy : assert property (
        @(posedge clk) disable iff (!rstn)
        cmd.start |-> !busy
    );

    // the memory only answers transfers that this block started.
    a_done_when_busy : assert property (
        @(posedge clk) disable iff (!rstn)
        mem_rsp.done |-> busy
    );

endmodule

/* cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// geometry of the cache.
`define CACHE_LINES 16
`define LINE_WORDS 4

// the backing store covers 4 KiB in lines of four words.
`define MEM_LINES 256

// cycles from a line-memory start to its done pulse, at least one.
`define MEM_LATENCY 4

// initial memory word at word address w is w ^ MEM_SEED.
`define MEM_SEED 32'h5a5a_0000

`endif

/* cache_pkg.sv */
`include "cache_params.svh"

package cache_pkg;

    // byte address as seen by the cache. The zero field and the upper two tag
    // bits stay zero inside the 4 KiB space.
    typedef struct packed {
        logic [17:0] zero;
        logic [5:0]  tag;
        logic [3:0]  index;
        logic [1:0]  word;
        logic [1:0]  byte_ofs;
    } cache_fields_t;

    typedef union packed {
        logic [31:0]   raw;
        cache_fields_t fields;
    } cache_addr_u;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        cache_addr_u adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [5:0] tag;
        logic       dirty;
        logic       valid;
    } tag_entry_t;

    typedef logic [`LINE_WORDS-1:0][31:0] line_t; // word 0 in the low bits.

    // one line transfer; addr is the line number {tag[3:0], index}.
    typedef struct packed {
        logic       start;
        logic       write;
        logic [7:0] addr;
        line_t      line;
    } mem_cmd_t;

    typedef struct packed {
        logic  done;
        line_t line;
    } mem_rsp_t;

endpackage

/* cache_tag_store.sv */
`include "cache_params.svh"

module cache_tag_store (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [3:0]            index,
    input  logic [5:0]            req_tag,
    input  logic                  we,
    input  cache_pkg::tag_entry_t wentry,
    output cache_pkg::tag_entry_t entry,
    output logic                  hit,
    output logic                  ready
);

    cache_pkg::tag_entry_t tags [`CACHE_LINES];

    logic [3:0] clr_idx;
    logic [5:0] tag_q;

    // after reset every entry is cleared once, one index per cycle.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            clr_idx <= '0;
            ready   <= 1'b0;
        end else if (!ready) begin
            clr_idx <= clr_idx + 4'd1;
            if (clr_idx == 4'(`CACHE_LINES - 1)) begin
                ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!ready) begin
            tags[clr_idx] <= '0;
        end else if (we) begin
            tags[index] <= wentry;
        end
        entry <= tags[index]; // read sees the old entry on a same-cycle write.
        tag_q <= req_tag;
    end

    // compare against the tag that was presented with the read.
    assign hit = entry.valid && (entry.tag == tag_q);

    // the controller must hold off until the sweep has finished.
    a_no_write_before_ready : assert property (
        @(posedge clk) disable iff (!rstn)
        we |-> ready
    );

endmodule

/* cache_top.sv */
module cache_top (
    input  logic               clk,
    input  logic               rstn,
    input  cache_pkg::wb_req_t wb_req,
    output cache_pkg::wb_rsp_t wb_rsp
);

    logic [3:0]            index;
    logic [5:0]            req_tag;
    cache_pkg::tag_entry_t entry;
    logic                  hit;
    logic                  ready;
    logic                  tag_we;
    cache_pkg::tag_entry_t wentry;
    cache_pkg::line_t      line;
    logic [1:0]            word;
    logic                  word_we;
    logic [31:0]           wdata;
    logic                  fill_we;
    cache_pkg::line_t      fill_line;
    cache_pkg::mem_cmd_t   ctl_cmd;
    cache_pkg::mem_rsp_t   ctl_rsp;
    cache_pkg::mem_cmd_t   mem_cmd;
    cache_pkg::mem_rsp_t   mem_rsp;

    cache_controller i_ctrl (
        .clk(clk), .rstn(rstn),
        .wb_req(wb_req), .wb_rsp(wb_rsp),
        .index(index), .req_tag(req_tag),
        .entry(entry), .hit(hit), .ready(ready),
        .tag_we(tag_we), .wentry(wentry),
        .line(line), .word(word), .word_we(word_we), .wdata(wdata),
        .fill_we(fill_we), .fill_line(fill_line),
        .mem_cmd(ctl_cmd), .mem_rsp(ctl_rsp)
    );

    cache_tag_store i_tags (
        .clk(clk), .rstn(rstn),
        .index(index), .req_tag(req_tag),
        .we(tag_we), .wentry(wentry),
        .entry(entry), .hit(hit), .ready(ready)
    );

    cache_data_store i_data (
        .clk(clk), .index(index), .word(word),
        .word_we(word_we), .wdata(wdata),
        .fill_we(fill_we), .fill_line(fill_line),
        .line(line)
    );

    cache_miss_handler i_miss (
        .clk(clk), .rstn(rstn),
        .cmd(ctl_cmd), .rsp(ctl_rsp),
        .mem_cmd(mem_cmd), .mem_rsp(mem_rsp)
    );

    line_memory i_mem (.clk(clk), .rstn(rstn), .cmd(mem_cmd), .rsp(mem_rsp));

endmodule

/* line_memory.sv */
`include "cache_params.svh"

module line_memory (
    input  logic                clk,
    input  logic                rstn,
    input  cache_pkg::mem_cmd_t cmd,
    output cache_pkg::mem_rsp_t rsp
);

    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    cache_pkg::line_t mem [`MEM_LINES];

    logic [CNT_W-1:0] cnt;
    cache_pkg::line_t rd_q;

    // content follows the seed pattern, word address xor seed.
    initial begin
        for (int l = 0; l < `MEM_LINES; l++) begin
            for (int w = 0; w < `LINE_WORDS; w++) begin
                mem[l][w] = 32'(l * `LINE_WORDS + w) ^ `MEM_SEED;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cnt <= '0;
        end else if (cmd.start) begin
            cnt <= CNT_W'(`MEM_LATENCY);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // the access itself happens at start and the counter only delays the answer.
    always_ff @(posedge clk) begin
        if (cmd.start) begin
            if (cmd.write) begin
                mem[cmd.addr] <= cmd.line;
            end else begin
                rd_q <= mem[cmd.addr];
            end
        end
    end

    assign rsp = '{done: cnt == CNT_W'(1), line: rd_q};

endmodule

/* tb_cache.sv */
`include "cache_params.svh"

module tb_cache;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int   N_RAND            = 40;
    localparam int   CYCLES_PER_ACCESS = 4 * `MEM_LATENCY + 20;
    localparam logic RD                = 1'b0;
    localparam logic WR                = 1'b1;
    localparam logic MISS              = 1'b0;
    localparam logic HIT               = 1'b1;

    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] data;
        logic        hit;
    } row_t;

    logic               clk;
    logic               rstn;
    cache_pkg::wb_req_t wb_req;
    cache_pkg::wb_rsp_t wb_rsp;

    logic [31:0] ref_mem [1024];
    logic        line_valid [`CACHE_LINES];
    logic [5:0]  line_tag [`CACHE_LINES];
    row_t        rows [$];
    integer      seed;

    cache_top i_dut (.clk(clk), .rstn(rstn), .wb_req(wb_req), .wb_rsp(wb_rsp));

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // one access budget per table row, per random access and for the reset access.
    initial begin
        int limit_ns;
        @(posedge clk); // the table is filled at time zero.
        limit_ns = (rows.size() + 1 + N_RAND) * CYCLES_PER_ACCESS * 100;
        #(limit_ns);
        fail_run("run timed out, a request was never acknowledged");
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic string err_line(input string name, input logic [31:0] exp,
                                       input logic [31:0] got);
        return $sformatf("ERR %0d ns: %s expected %h got %h", $time, name, exp, got);
    endfunction

    task automatic drive_request(input logic we, input logic [31:0] addr,
                                 input logic [31:0] data);
        wb_req.cyc     = 1'b1;
        wb_req.stb     = 1'b1;
        wb_req.we      = we;
        wb_req.adr.raw = addr;
        wb_req.dat     = data;
    endtask

    // the first falling edge comes before the request is sampled, so a hit
    // shows ack at the fourth falling edge after the request is driven.
    task automatic wait_ack(output int latency, output logic [31:0] rdata);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (wb_rsp.ack !== 1'b1);
        latency = n - 2;
        rdata   = wb_rsp.dat;
    endtask

    task automatic release_bus();
        @(posedge clk);
        #10;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
        assert (wb_rsp.ack === 1'b0) // ack lasts a single cycle.
            else fail_run(err_line("wb_rsp.ack", 32'd0, 32'(wb_rsp.ack)));
    endtask

    task automatic check_no_ack();
        @(posedge clk);
        #10;
        assert (wb_rsp.ack === 1'b0)
            else fail_run(err_line("wb_rsp.ack", 32'd0, 32'(wb_rsp.ack)));
    endtask

    // direct mapped, so the accessed line always ends up holding this tag.
    task automatic note_line(input logic [31:0] addr);
        line_valid[addr[7:4]] = 1'b1;
        line_tag[addr[7:4]]   = addr[13:8];
    endtask

    function automatic logic predict_hit(input logic [31:0] addr);
        return line_valid[addr[7:4]] && (line_tag[addr[7:4]] == addr[13:8]);
    endfunction

    task automatic run_access(input logic we, input logic [31:0] addr,
                              input logic [31:0] data, input logic exp_hit);
        logic [31:0] rdata;
        int          latency;
        int          w;
        w = addr[11:2];
        @(posedge clk);
        #10;
        drive_request(we, addr, data);
        wait_ack(latency, rdata);
        if (exp_hit) begin
            assert (latency == 2)
                else fail_run(err_line("ack latency", 32'd2, 32'(latency)));
        end else begin
            assert (latency > 2)
                else fail_run($sformatf("miss at address %h acknowledged after only %0d cycles",
                                        addr, latency));
        end
        if (we) begin
            ref_mem[w] = data;
        end else begin
            assert (rdata === ref_mem[w])
                else fail_run(err_line("wb_rsp.dat", ref_mem[w], rdata));
        end
        note_line(addr);
        release_bus();
    endtask

    task automatic add_row(input logic we, input logic [31:0] addr, input logic [31:0] data,
                           input logic hit);
        rows.push_back('{we: we, addr: addr, data: data, hit: hit});
    endtask

    // index 2 is shared by tags 1 and 3, index 4 by tags 0 and 15.
    task automatic fill_table();
        add_row(RD, 32'h120, 32'h0,         MISS); // clean miss returns the pattern word.
        add_row(RD, 32'h124, 32'h0,         HIT);
        add_row(RD, 32'h12c, 32'h0,         HIT);
        add_row(RD, 32'h120, 32'h0,         HIT);
        add_row(WR, 32'h128, 32'hdead_beef, HIT);
        add_row(RD, 32'h128, 32'h0,         HIT);
        add_row(RD, 32'h124, 32'h0,         HIT);
        add_row(RD, 32'h12c, 32'h0,         HIT);
        add_row(WR, 32'h324, 32'h1234_5678, MISS); // evicts the dirty line.
        add_row(RD, 32'h324, 32'h0,         HIT);
        add_row(RD, 32'h128, 32'h0,         MISS); // comes back from memory.
        add_row(RD, 32'h120, 32'h0,         HIT);
        add_row(RD, 32'h324, 32'h0,         MISS);
        add_row(WR, 32'h040, 32'ha5a5_0001, HIT);
        add_row(RD, 32'hf40, 32'h0,         MISS);
        add_row(RD, 32'h040, 32'h0,         MISS);
        add_row(RD, 32'hffc, 32'h0,         MISS);
        add_row(RD, 32'hff0, 32'h0,         HIT);
    endtask

    initial begin
        logic [31:0] rdata;
        logic [31:0] rnd;
        logic [31:0] addr;
        int          latency;
        seed   = 28;
        rstn   = 1'b0;
        wb_req = '0;
        for (int w = 0; w < 1024; w++) begin
            ref_mem[w] = 32'(w) ^ `MEM_SEED;
        end
        for (int i = 0; i < `CACHE_LINES; i++) begin
            line_valid[i] = 1'b0;
            line_tag[i]   = '0;
        end
        fill_table();

        // this read waits through reset and the whole tag clear sweep.
        drive_request(RD, 32'h040, 32'h0);
        repeat (4) check_no_ack();
        rstn = 1'b1;
        repeat (`CACHE_LINES) check_no_ack();
        wait_ack(latency, rdata);
        assert (rdata === ref_mem[32'h040 >> 2])
            else fail_run(err_line("wb_rsp.dat", ref_mem[32'h040 >> 2], rdata));
        note_line(32'h040);
        release_bus();

        foreach (rows[i]) begin
            run_access(rows[i].we, rows[i].addr, rows[i].data, rows[i].hit);
        end

        repeat (N_RAND) begin
            rnd  = $random(seed);
            addr = rnd & 32'h0000_0ffc;
            rnd  = $random(seed);
            run_access(rnd[0], addr, $random(seed), predict_hit(addr));
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
cache_pkg.sv
cache_tag_store.sv
cache_data_store.sv
cache_controller.sv
cache_miss_handler.sv
line_memory.sv
cache_top.sv
tb_cache.sv
